//--- dv/tb_tex_cache.sv
// directed tests of the texture cache; strides are fixed, one request in flight per unit
module tb_tex_cache;
    import tex_cache_pkg::*;

    localparam int ACCESS_NUM     = 60;
    localparam int DIRECTED_NUM   = 12;
    localparam int FILL_CYCLES    = 60;
    localparam int RSP_LIMIT      = 200;
    localparam int WATCHDOG_TIME  = (ACCESS_NUM + DIRECTED_NUM) * FILL_CYCLES * 20 * 2;

    logic                       clk;
    logic                       reset;
    tex_req_t                   req;
    tex_rsp_t [UNIT_NUM-1:0]    rsp;
    logic [ADDR_WIDTH-1:0]      param_addr;
    logic [STRIDE_WIDTH-1:0]    param_stride_x;
    logic [STRIDE_WIDTH-1:0]    param_stride_y;
    logic                       clear_start;
    logic                       clear_busy;
    logic [WORD_ADDR_WIDTH-1:0] mem_raddr;
    logic                       mem_rd;
    logic [WORD_WIDTH-1:0]      mem_rdata;
    logic                       mem_rvalid;

    int          errors;
    int          checks;
    logic        run_done;
    logic [31:0] rnd_state;
    logic        model_valid [UNIT_NUM][8];
    logic [11:0] model_tag   [UNIT_NUM][8];
    logic [WORD_ADDR_WIDTH-1:0] raddr_q [$];

    tex_cache_top uut (.*);

    tex_mem_model u_mem (
        .clk        (clk),
        .reset      (reset),
        .mem_rd     (mem_rd),
        .mem_raddr  (mem_raddr),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid)
    );

    always #10 clk = ~clk;

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units", WATCHDOG_TIME);
        run_done = 1'b1;
        $display("Test failed");
        $finish;
    end

    final begin
        if (!run_done) begin
            $display("Test failed");
        end
    end

    // ----------------------------------------
    // reference rules
    // ----------------------------------------
    function automatic logic [ADDR_WIDTH-1:0] block_addr(input logic [7:0] x,
                                                         input logic [7:0] y);
        return param_addr + ADDR_WIDTH'(y / 4) * ADDR_WIDTH'(param_stride_y)
               + ADDR_WIDTH'(x / 4) * ADDR_WIDTH'(param_stride_x);
    endfunction

    function automatic logic [7:0] expected_texel(input logic [7:0] x, input logic [7:0] y);
        logic [ADDR_WIDTH-1:0] a;
        logic [ADDR_WIDTH-1:0] prod;
        a    = block_addr(x, y) + ADDR_WIDTH'((y % 4) * 4) + ADDR_WIDTH'(x % 4);
        prod = a * 7;
        return prod[7:0] ^ a[ADDR_WIDTH-1:ADDR_WIDTH-8];
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            rnd_state = lfsr_step(rnd_state);
            v         = {v[6:0], rnd_state[0]};
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp)
        else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic log_result(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic clear_model();
        for (int u = 0; u < UNIT_NUM; u++) begin
            for (int l = 0; l < 8; l++) begin
                model_valid[u][l] = 1'b0;
            end
        end
    endtask

    // row reads of each fill, in grant order
    always @(negedge clk) begin
        if (!reset && mem_rd) begin
            if (raddr_q.size() == 0) begin
                check_true(1'b0, $sformatf("unexpected memory read at %h", mem_raddr));
            end else begin
                check_value("mem_raddr", 32'(mem_raddr), 32'(raddr_q.pop_front()));
            end
        end
    end

    // ----------------------------------------
    // accesses
    // ----------------------------------------
    // up to two requests, one cycle apart, each to a different unit
    task automatic run_access(input int n, input logic [7:0] x0, input logic [7:0] y0,
                              input logic [7:0] x1, input logic [7:0] y1);
        logic [7:0]            xs        [2];
        logic [7:0]            ys        [2];
        logic                  own       [2];
        logic [2:0]            line      [2];
        logic                  ehit      [2];
        logic                  got       [2];
        logic                  hit_got   [2];
        logic [7:0]            texel_got [2];
        int                    at        [2];
        int                    cycles;
        int                    k;
        logic [ADDR_WIDTH-1:0] base;
        xs[0] = x0;
        ys[0] = y0;
        xs[1] = x1;
        ys[1] = y1;
        got[0] = 1'b0;
        got[1] = 1'b0;
        for (int i = 0; i < n; i++) begin
            own[i]  = xs[i][2] ^ ys[i][2];
            line[i] = {ys[i][3:2], xs[i][3]};
            ehit[i] = model_valid[own[i]][line[i]] &&
                      model_tag[own[i]][line[i]] == {xs[i][7:2], ys[i][7:2]};
            if (!ehit[i]) begin
                base = block_addr(xs[i], ys[i]);
                for (int r = 0; r < ROW_NUM; r++) begin
                    raddr_q.push_back(base[ADDR_WIDTH-1:2] + WORD_ADDR_WIDTH'(r));
                end
            end
        end
        cycles = 0;
        while (!(got[0] && (n == 1 || got[1])) && cycles < RSP_LIMIT) begin
            if (cycles < n) begin
                req = '{valid: 1'b1, x: xs[cycles], y: ys[cycles]};
            end else begin
                req = '0;
            end
            wait_cycle();
            cycles++;
            for (int u = 0; u < UNIT_NUM; u++) begin
                if (rsp[u].valid) begin
                    k = -1;
                    for (int i = 0; i < n; i++) begin
                        if (own[i] == 1'(u) && !got[i]) begin
                            k = i;
                        end
                    end
                    check_true(k >= 0,
                               $sformatf("unit %0d answered a request it does not own", u));
                    if (k >= 0) begin
                        got[k]       = 1'b1;
                        at[k]        = cycles;
                        hit_got[k]   = rsp[u].hit;
                        texel_got[k] = rsp[u].texel;
                    end
                end
            end
        end
        req = '0;
        for (int i = 0; i < n; i++) begin
            check_true(got[i], $sformatf("no response for x=%0d y=%0d within %0d cycles",
                                         xs[i], ys[i], RSP_LIMIT));
            if (got[i]) begin
                check_value("rsp.hit", 32'(hit_got[i]), 32'(ehit[i]));
                check_value("rsp.texel", 32'(texel_got[i]), 32'(expected_texel(xs[i], ys[i])));
                if (ehit[i]) begin
                    check_value("hit latency", 32'(at[i] - i), 32'd2);
                end
            end
            model_valid[own[i]][line[i]] = 1'b1;
            model_tag[own[i]][line[i]]   = {xs[i][7:2], ys[i][7:2]};
        end
        if (n == 2 && !ehit[0] && !ehit[1] && got[0] && got[1]) begin
            check_true(at[1] > at[0], "second fill did not complete after the first");
        end
        check_true(raddr_q.size() == 0, "expected memory reads were not issued");
        raddr_q.delete();
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic reset_state();
        for (int u = 0; u < UNIT_NUM; u++) begin
            check_value($sformatf("rsp[%0d].valid", u), 32'(rsp[u].valid), 32'd0);
        end
        check_value("mem_rd", 32'(mem_rd), 32'd0);
        check_value("clear_busy", 32'(clear_busy), 32'd0);
    endtask

    task automatic first_access();
        run_access(1, 8'd10, 8'd6, 8'd0, 8'd0);
    endtask

    task automatic same_block_hit();
        run_access(1, 8'd11, 8'd7, 8'd0, 8'd0);
    endtask

    task automatic two_unit_fills();
        run_access(2, 8'd0, 8'd8, 8'd20, 8'd8);
    endtask

    // blocks (1,0) and (49,0) share unit 1 line 0
    task automatic index_eviction();
        run_access(1, 8'd4, 8'd0, 8'd0, 8'd0);
        run_access(1, 8'd196, 8'd0, 8'd0, 8'd0);
        run_access(1, 8'd5, 8'd1, 8'd0, 8'd0);
        run_access(1, 8'd197, 8'd2, 8'd0, 8'd0);
    endtask

    task automatic clear_sweep();
        int busy_cycles;
        run_access(2, 8'd11, 8'd6, 8'd1, 8'd9);
        clear_start = 1'b1;
        wait_cycle();
        clear_start = 1'b0;
        busy_cycles = 0;
        while (clear_busy && busy_cycles < 20) begin
            busy_cycles++;
            wait_cycle();
        end
        check_value("clear_busy cycles", 32'(busy_cycles), 32'd8);
        clear_model();
        run_access(2, 8'd9, 8'd5, 8'd1, 8'd9);
    endtask

    task automatic random_sweep();
        logic [7:0] x0;
        logic [7:0] y0;
        logic [7:0] x1;
        logic [7:0] y1;
        logic [7:0] pick;
        for (int s = 0; s < ACCESS_NUM; s++) begin
            take_bits(5, x0);
            take_bits(4, y0);
            take_bits(5, x1);
            take_bits(4, y1);
            take_bits(1, pick);
            if ((x0[2] ^ y0[2]) == (x1[2] ^ y1[2])) begin
                x1[2] = !x1[2];
            end
            run_access(pick[0] ? 2 : 1, x0, y0, x1, y1);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int mark;
        clk            = 1'b0;
        reset          = 1'b1;
        req            = '0;
        clear_start    = 1'b0;
        param_addr     = 24'h12_3400;
        param_stride_x = 14'd16;
        param_stride_y = 14'd1040;
        errors         = 0;
        checks         = 0;
        run_done       = 1'b0;
        rnd_state      = 32'hfc6d_97e0;
        clear_model();
        repeat (8) wait_cycle();
        reset = 1'b0;

        mark = errors;
        reset_state();
        log_result("reset state", mark);
        mark = errors;
        first_access();
        log_result("first access", mark);
        mark = errors;
        same_block_hit();
        log_result("same block hit", mark);
        mark = errors;
        two_unit_fills();
        log_result("two unit fills", mark);
        mark = errors;
        index_eviction();
        log_result("index eviction", mark);
        mark = errors;
        clear_sweep();
        log_result("clear sweep", mark);
        mark = errors;
        random_sweep();
        log_result("random sweep", mark);

        $display("%0d checks, %0d errors", checks, errors);
        run_done = 1'b1;
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/tex_cache_assert.sv
// fill path checks on the arbiter; assumes block_fetch marks the fourth beat of each fill last
module tex_cache_assert (
    input logic                                                 clk,
    input logic                                                 reset,
    input tex_cache_pkg::fill_req_t                             fetch_req,
    input tex_cache_pkg::fill_beat_t                            fetch_beat,
    input tex_cache_pkg::fill_beat_t [tex_cache_pkg::UNIT_NUM-1:0] fill_beat_out
);
    import tex_cache_pkg::*;

    logic [UNIT_NUM-1:0] beat_valid;
    logic                in_flight;

    always_comb begin
        for (int i = 0; i < UNIT_NUM; i++) begin
            beat_valid[i] = fill_beat_out[i].valid;
        end
    end

    // a fill lasts from its fetch request to its last beat
    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 1'b0;
        end else if (fetch_req.valid) begin
            in_flight <= 1'b1;
        end else if (fetch_beat.valid && fetch_beat.last) begin
            in_flight <= 1'b0;
        end
    end

    a_no_fetch_in_flight: assert property (@(posedge clk) disable iff (reset)
        fetch_req.valid |-> !in_flight)
        else $error("fetch request while a fill is in flight");

    a_beat_one_owner: assert property (@(posedge clk) disable iff (reset)
        $countones(beat_valid) == (fetch_beat.valid ? 1 : 0))
        else $error("fill beat not routed to exactly one unit");

endmodule

bind fill_arbiter tex_cache_assert u_fill_assert (
    .clk           (clk),
    .reset         (reset),
    .fetch_req     (fetch_req),
    .fetch_beat    (fetch_beat),
    .fill_beat_out (fill_beat_out)
);

//--- dv/tex_mem_model.sv
// word-addressed read memory; latency 1 to 8 cycles from an LFSR, replies kept in order
module tex_mem_model (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      mem_rd,
    input  logic [tex_cache_pkg::WORD_ADDR_WIDTH-1:0] mem_raddr,
    output logic [tex_cache_pkg::WORD_WIDTH-1:0]      mem_rdata,
    output logic                                      mem_rvalid
);
    import tex_cache_pkg::*;

    logic [WORD_ADDR_WIDTH-1:0] addr_q [$];
    int                         due_q  [$];
    int                         cycle;
    int                         last_due;
    logic [31:0]                lat_lfsr;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // byte value depends on the full byte address
    function automatic logic [7:0] byte_at(input logic [ADDR_WIDTH-1:0] a);
        logic [ADDR_WIDTH-1:0] prod;
        prod = a * 7;
        return prod[7:0] ^ a[ADDR_WIDTH-1:ADDR_WIDTH-8];
    endfunction

    function automatic logic [WORD_WIDTH-1:0] word_at(input logic [WORD_ADDR_WIDTH-1:0] w);
        logic [WORD_WIDTH-1:0] word;
        for (int b = 0; b < 4; b++) begin
            word[8*b +: 8] = byte_at({w, 2'b00} + ADDR_WIDTH'(b));
        end
        return word;
    endfunction

    initial begin
        logic [2:0] lat_bits;
        int         due;
        lat_lfsr   = 32'hfc6d_97e0;
        cycle      = 0;
        last_due   = 0;
        mem_rdata  = '0;
        mem_rvalid = 1'b0;
        forever begin
            @(posedge clk);
            cycle++;
            if (reset) begin
                addr_q.delete();
                due_q.delete();
            end else if (mem_rd) begin
                for (int i = 0; i < 3; i++) begin
                    lat_lfsr    = lfsr_step(lat_lfsr);
                    lat_bits[i] = lat_lfsr[0];
                end
                due      = cycle + int'(lat_bits) + 1;
                due      = (due > last_due) ? due : last_due + 1;
                last_due = due;
                addr_q.push_back(mem_raddr);
                due_q.push_back(due);
            end
            #1;
            mem_rvalid = 1'b0;
            mem_rdata  = '0;
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                mem_rvalid = 1'b1;
                mem_rdata  = word_at(addr_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

endmodule

//--- rtl/block_fetch.sv
// block address pipeline and row reads; base and strides must be word aligned, memory in order
module block_fetch (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [tex_cache_pkg::ADDR_WIDTH-1:0]     param_addr,
    input  logic [tex_cache_pkg::STRIDE_WIDTH-1:0]   param_stride_x,
    input  logic [tex_cache_pkg::STRIDE_WIDTH-1:0]   param_stride_y,
    input  tex_cache_pkg::fill_req_t                 fetch_req,
    output tex_cache_pkg::fill_beat_t                fetch_beat,
    output logic [tex_cache_pkg::WORD_ADDR_WIDTH-1:0] mem_raddr,
    output logic                                     mem_rd,
    input  logic [tex_cache_pkg::WORD_WIDTH-1:0]     mem_rdata,
    input  logic                                     mem_rvalid
);
    import tex_cache_pkg::*;

    logic                     st1_valid;
    logic [ADDR_WIDTH-1:0]    st1_prod_x;
    logic [ADDR_WIDTH-1:0]    st1_prod_y;
    logic                     st2_valid;
    logic [ADDR_WIDTH-1:0]    st2_sum;
    logic [ADDR_WIDTH-1:0]    base_addr;

    logic                     rd_busy;
    logic [ROW_IDX_WIDTH-1:0] rd_row;
    logic [ROW_IDX_WIDTH-1:0] ret_row;

    // ----------------------------------------
    // address pipeline
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid <= 1'b0;
            st2_valid <= 1'b0;
        end else begin
            st1_valid <= fetch_req.valid;
            st2_valid <= st1_valid;
        end
    end

    always_ff @(posedge clk) begin
        // stage 1 strides
        st1_prod_x <= ADDR_WIDTH'(fetch_req.blk_x) * ADDR_WIDTH'(param_stride_x);
        st1_prod_y <= ADDR_WIDTH'(fetch_req.blk_y) * ADDR_WIDTH'(param_stride_y);
        // stage 2 sum
        st2_sum <= st1_prod_x + st1_prod_y;
        // stage 3 base
        if (st2_valid) begin
            base_addr <= st2_sum + param_addr;
        end
    end

    // ----------------------------------------
    // row reads
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_busy <= 1'b0;
            rd_row  <= '0;
        end else if (st2_valid) begin
            rd_busy <= 1'b1;
            rd_row  <= '0;
        end else if (rd_busy) begin
            rd_row <= rd_row + 1'b1;
            if (rd_row == ROW_IDX_WIDTH'(ROW_NUM - 1)) begin
                rd_busy <= 1'b0;
            end
        end
    end

    // one word per texel row
    assign mem_rd    = rd_busy;
    assign mem_raddr = base_addr[ADDR_WIDTH-1:2] + WORD_ADDR_WIDTH'(rd_row);

    // ----------------------------------------
    // returns
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ret_row <= '0;
        end else if (mem_rvalid) begin
            ret_row <= ret_row + 1'b1;
        end
    end

    assign fetch_beat = '{
        valid: mem_rvalid,
        last:  (ret_row == ROW_IDX_WIDTH'(ROW_NUM - 1)),
        row:   ret_row,
        word:  mem_rdata
    };

endmodule

//--- rtl/fill_arbiter.sv
// round-robin owner of the single fill path; one fill in flight, a unit asks once per miss
module fill_arbiter (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  tex_cache_pkg::fill_req_t  [tex_cache_pkg::UNIT_NUM-1:0] fill_req_in,
    output tex_cache_pkg::fill_beat_t [tex_cache_pkg::UNIT_NUM-1:0] fill_beat_out,
    output tex_cache_pkg::fill_req_t                             fetch_req,
    input  tex_cache_pkg::fill_beat_t                            fetch_beat
);
    import tex_cache_pkg::*;

    logic [UNIT_NUM-1:0]        pending;
    logic [BLK_COORD_WIDTH-1:0] pend_x [UNIT_NUM];
    logic [BLK_COORD_WIDTH-1:0] pend_y [UNIT_NUM];

    logic                       busy;
    logic [UNIT_ID_WIDTH-1:0]   grant_id;
    logic [UNIT_ID_WIDTH-1:0]   last_id;
    logic                       pick_valid;
    logic [UNIT_ID_WIDTH-1:0]   pick_id;

    logic                       fetch_valid;
    logic [BLK_COORD_WIDTH-1:0] fetch_x;
    logic [BLK_COORD_WIDTH-1:0] fetch_y;

    // search starts at the unit after the last one served
    always_comb begin
        logic [UNIT_ID_WIDTH-1:0] cand;
        pick_valid = 1'b0;
        pick_id    = last_id;
        for (int k = 1; k <= UNIT_NUM; k++) begin
            cand = UNIT_ID_WIDTH'((int'(last_id) + k) % UNIT_NUM);
            if (!pick_valid && pending[cand]) begin
                pick_valid = 1'b1;
                pick_id    = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending     <= '0;
            busy        <= 1'b0;
            grant_id    <= '0;
            last_id     <= UNIT_ID_WIDTH'(UNIT_NUM - 1);
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            for (int i = 0; i < UNIT_NUM; i++) begin
                if (fill_req_in[i].valid) begin
                    pending[i] <= 1'b1;
                end
            end
            if (!busy && pick_valid) begin
                busy             <= 1'b1;
                grant_id         <= pick_id;
                pending[pick_id] <= 1'b0;
                fetch_valid      <= 1'b1;
            end
            if (busy && fetch_beat.valid && fetch_beat.last) begin
                busy    <= 1'b0;
                last_id <= grant_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < UNIT_NUM; i++) begin
            if (fill_req_in[i].valid) begin
                pend_x[i] <= fill_req_in[i].blk_x;
                pend_y[i] <= fill_req_in[i].blk_y;
            end
        end
        fetch_x <= pend_x[pick_id];
        fetch_y <= pend_y[pick_id];
    end

    assign fetch_req = '{valid: fetch_valid, blk_x: fetch_x, blk_y: fetch_y};

    // beats only reach the granted unit
    always_comb begin
        for (int i = 0; i < UNIT_NUM; i++) begin
            fill_beat_out[i]       = fetch_beat;
            fill_beat_out[i].valid = fetch_beat.valid && busy && (grant_id == UNIT_ID_WIDTH'(i));
        end
    end

endmodule

//--- rtl/tex_cache_pkg.sv
// shared types for the texture cache; ownership and tag indexing assume two units of 8 lines
package tex_cache_pkg;

    // ----------------------------------------
    // geometry and widths
    // ----------------------------------------
    localparam int COORD_WIDTH     = 8;
    localparam int BLK_SIZE        = 2;
    localparam int BLK_COORD_WIDTH = COORD_WIDTH - BLK_SIZE;
    localparam int UNIT_NUM        = 2;
    localparam int UNIT_ID_WIDTH   = 1;
    localparam int TAG_INDEX_WIDTH = 3;
    localparam int ADDR_WIDTH      = 24;
    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;
    localparam int STRIDE_WIDTH    = 14;
    localparam int WORD_WIDTH      = 32;
    localparam int ROW_NUM         = 4;
    localparam int ROW_IDX_WIDTH   = 2;
    localparam int TEXEL_WIDTH     = 8;

    // ----------------------------------------
    // packets
    // ----------------------------------------
    typedef struct packed {
        logic                       valid;
        logic [COORD_WIDTH-1:0]     x;
        logic [COORD_WIDTH-1:0]     y;
    } tex_req_t;

    typedef struct packed {
        logic                       valid;
        logic                       hit;
        logic [TEXEL_WIDTH-1:0]     texel;
    } tex_rsp_t;

    typedef struct packed {
        logic                       valid;
        logic [BLK_COORD_WIDTH-1:0] blk_x;
        logic [BLK_COORD_WIDTH-1:0] blk_y;
    } fill_req_t;

    // one texel row of a block per beat
    typedef struct packed {
        logic                       valid;
        logic                       last;
        logic [ROW_IDX_WIDTH-1:0]   row;
        logic [WORD_WIDTH-1:0]      word;
    } fill_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        CLEAR
    } unit_state_t;

endpackage

//--- rtl/tex_cache_top.sv
// texture cache top; one outstanding request per unit, no back-pressure on any path
module tex_cache_top (
    input  logic                                      clk,
    input  logic                                      reset,
    input  tex_cache_pkg::tex_req_t                   req,
    output tex_cache_pkg::tex_rsp_t [tex_cache_pkg::UNIT_NUM-1:0] rsp,
    input  logic [tex_cache_pkg::ADDR_WIDTH-1:0]      param_addr,
    input  logic [tex_cache_pkg::STRIDE_WIDTH-1:0]    param_stride_x,
    input  logic [tex_cache_pkg::STRIDE_WIDTH-1:0]    param_stride_y,
    input  logic                                      clear_start,
    output logic                                      clear_busy,
    output logic [tex_cache_pkg::WORD_ADDR_WIDTH-1:0] mem_raddr,
    output logic                                      mem_rd,
    input  logic [tex_cache_pkg::WORD_WIDTH-1:0]      mem_rdata,
    input  logic                                      mem_rvalid
);
    import tex_cache_pkg::*;

    fill_req_t  [UNIT_NUM-1:0] unit_fill_req;
    fill_beat_t [UNIT_NUM-1:0] unit_fill_beat;
    logic       [UNIT_NUM-1:0] unit_clear_busy;
    fill_req_t                 fetch_req;
    fill_beat_t                fetch_beat;

    // units sweep in lockstep
    assign clear_busy = unit_clear_busy[0];

    for (genvar i = 0; i < UNIT_NUM; i++) begin : g_unit
        tex_cache_unit #(
            .UNIT_ID     (UNIT_ID_WIDTH'(i))
        ) u_unit (
            .clk         (clk),
            .reset       (reset),
            .req         (req),
            .rsp         (rsp[i]),
            .clear_start (clear_start),
            .clear_busy  (unit_clear_busy[i]),
            .fill_req    (unit_fill_req[i]),
            .fill_beat   (unit_fill_beat[i])
        );
    end

    fill_arbiter u_arbiter (
        .clk           (clk),
        .reset         (reset),
        .fill_req_in   (unit_fill_req),
        .fill_beat_out (unit_fill_beat),
        .fetch_req     (fetch_req),
        .fetch_beat    (fetch_beat)
    );

    block_fetch u_fetch (
        .clk            (clk),
        .reset          (reset),
        .param_addr     (param_addr),
        .param_stride_x (param_stride_x),
        .param_stride_y (param_stride_y),
        .fetch_req      (fetch_req),
        .fetch_beat     (fetch_beat),
        .mem_raddr      (mem_raddr),
        .mem_rd         (mem_rd),
        .mem_rdata      (mem_rdata),
        .mem_rvalid     (mem_rvalid)
    );

endmodule

//--- rtl/tex_cache_unit.sv
// one direct-mapped cache unit; one request in flight, clear_start is taken only while idle
module tex_cache_unit #(
    parameter logic [tex_cache_pkg::UNIT_ID_WIDTH-1:0] UNIT_ID = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  tex_cache_pkg::tex_req_t   req,
    output tex_cache_pkg::tex_rsp_t   rsp,
    input  logic                      clear_start,
    output logic                      clear_busy,
    output tex_cache_pkg::fill_req_t  fill_req,
    input  tex_cache_pkg::fill_beat_t fill_beat
);
    import tex_cache_pkg::*;

    localparam int LINE_NUM  = 1 << TAG_INDEX_WIDTH;
    localparam int TAG_WIDTH = 2 * BLK_COORD_WIDTH;

    unit_state_t state;

    logic [COORD_WIDTH-1:0]     cur_x;
    logic [COORD_WIDTH-1:0]     cur_y;
    logic [BLK_COORD_WIDTH-1:0] cur_blk_x;
    logic [BLK_COORD_WIDTH-1:0] cur_blk_y;
    logic [TAG_INDEX_WIDTH-1:0] cur_index;
    logic [TAG_WIDTH-1:0]       cur_tag;

    logic [TAG_WIDTH-1:0]       tag_mem   [LINE_NUM];
    logic [LINE_NUM-1:0]        tag_valid;
    logic [WORD_WIDTH-1:0]      data_mem  [LINE_NUM][ROW_NUM];

    logic                       own;
    logic                       hit;
    logic                       refill;
    logic [WORD_WIDTH-1:0]      row_word;
    logic [TEXEL_WIDTH-1:0]     sel_texel;
    logic [TAG_INDEX_WIDTH-1:0] clr_index;

    logic                       rsp_valid;
    logic                       rsp_hit;
    logic [TEXEL_WIDTH-1:0]     rsp_texel;

    // checkerboard ownership on block coordinates
    assign own = req.valid && ((req.x[BLK_SIZE] ^ req.y[BLK_SIZE]) == UNIT_ID);

    assign cur_blk_x = cur_x[COORD_WIDTH-1:BLK_SIZE];
    assign cur_blk_y = cur_y[COORD_WIDTH-1:BLK_SIZE];
    // bit 0 of blk_x is implied by blk_y and the unit id
    assign cur_index = {cur_blk_y[1:0], cur_blk_x[1]};
    assign cur_tag   = {cur_blk_x, cur_blk_y};

    // ----------------------------------------
    // lookup
    // ----------------------------------------
    assign hit       = tag_valid[cur_index] && (tag_mem[cur_index] == cur_tag);
    assign row_word  = data_mem[cur_index][cur_y[BLK_SIZE-1:0]];
    assign sel_texel = row_word[TEXEL_WIDTH*cur_x[BLK_SIZE-1:0] +: TEXEL_WIDTH];

    assign fill_req   = '{valid: (state == LOOKUP) && !hit, blk_x: cur_blk_x, blk_y: cur_blk_y};
    assign clear_busy = (state == CLEAR);
    assign rsp        = '{valid: rsp_valid, hit: rsp_hit, texel: rsp_texel};

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            tag_valid <= '0;
            clr_index <= '0;
            refill    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (clear_start) begin
                        clr_index <= '0;
                        state     <= CLEAR;
                    end else if (own) begin
                        refill <= 1'b0;
                        state  <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        rsp_valid <= 1'b1;
                        state     <= IDLE;
                    end else begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (fill_beat.valid && fill_beat.last) begin
                        tag_valid[cur_index] <= 1'b1;
                        // second pass through lookup answers from the new line
                        refill <= 1'b1;
                        state  <= LOOKUP;
                    end
                end
                CLEAR: begin
                    tag_valid[clr_index] <= 1'b0;
                    clr_index            <= clr_index + 1'b1;
                    if (clr_index == '1) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // stores and payload
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (state == IDLE && own) begin
            cur_x <= req.x;
            cur_y <= req.y;
        end
        if (state == FILL && fill_beat.valid) begin
            data_mem[cur_index][fill_beat.row] <= fill_beat.word;
            if (fill_beat.last) begin
                tag_mem[cur_index] <= cur_tag;
            end
        end
        if (state == LOOKUP) begin
            rsp_hit   <= !refill;
            rsp_texel <= sel_texel;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the texture cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tex_cache -f vlog.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
exit 0

//--- vlog.f
rtl/tex_cache_pkg.sv
rtl/tex_cache_unit.sv
rtl/fill_arbiter.sv
rtl/block_fetch.sv
rtl/tex_cache_top.sv
dv/tex_mem_model.sv
dv/tex_cache_assert.sv
dv/tb_tex_cache.sv
